//--- mm2s_adv.f
+incdir+verilog
verilog/mm2s_pkg.sv
verilog/line_wr_if.sv
verilog/addr_seq_if.sv
verilog/scale_1d.sv
verilog/line_reader.sv
verilog/pingpong_line_buffer.sv
verilog/stream_out.sv
verilog/mm2s_adv.sv
verif/mm2s_adv_assert.sv
verif/mm2s_adv_tb.sv

//--- Bender.yml
package:
  name: mm2s_adv

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mm2s_pkg.sv
      - verilog/line_wr_if.sv
      - verilog/addr_seq_if.sv
      - verilog/scale_1d.sv
      - verilog/line_reader.sv
      - verilog/pingpong_line_buffer.sv
      - verilog/stream_out.sv
      - verilog/mm2s_adv.sv
  - target: test
    files:
      - verif/mm2s_adv_assert.sv
      - verif/mm2s_adv_tb.sv

//--- verif/mm2s_adv_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mm2s_adv_tb import mm2s_pkg::*; ();
	localparam int STRIDE = 1024;
	localparam int FRAME_TIMEOUT = 40000;

	logic clk;
	logic resetn;
	logic fsync;
	logic soft_resetn;
	col_t img_width;
	row_t img_height;
	col_t win_left;
	col_t win_width;
	row_t win_top;
	row_t win_height;
	col_t dst_width;
	row_t dst_height;
	axi_addr_t frame_addr;
	logic sof;
	axi_addr_t m_axi_araddr;
	logic [7:0] m_axi_arlen;
	logic [2:0] m_axi_arsize;
	logic [1:0] m_axi_arburst;
	logic m_axi_arlock;
	logic [3:0] m_axi_arcache;
	logic [2:0] m_axi_arprot;
	logic [3:0] m_axi_arqos;
	logic m_axi_arvalid;
	logic m_axi_arready;
	logic [31:0] m_axi_rdata;
	logic m_axi_rlast;
	logic m_axi_rvalid;
	logic m_axi_rready;
	logic m_axis_tvalid;
	pixel_t m_axis_tdata;
	logic m_axis_tuser;
	logic m_axis_tlast;
	logic m_axis_tready;

	integer seed;
	logic random_gaps;
	int beat_count;
	int frame_beats;
	int sof_count;
	int pos_x;
	int pos_y;

	// memory slave state for the one outstanding burst
	logic burst_active;
	axi_addr_t burst_addr;
	int beats_left;
	logic ar_fire;
	logic r_fire;
	logic gaps;

	mm2s_adv mm2s_adv_inst (.*);

	always #2 clk = ~clk;

	function automatic pixel_t memory_byte(axi_addr_t addr);
		return addr[7:0] ^ addr[15:8];
	endfunction

	function automatic logic [31:0] memory_word(axi_addr_t addr);
		return {memory_byte(addr + 3), memory_byte(addr + 2),
			memory_byte(addr + 1), memory_byte(addr)};
	endfunction

	// nearest source pixel for destination sample (x, y)
	function automatic pixel_t expected_pixel(int x, int y);
		int src_row;
		int src_col;
		src_row = win_top + (y * win_height) / dst_height;
		src_col = win_left + (x * win_width) / dst_width;
		return memory_byte(frame_addr + src_row * STRIDE + src_col);
	endfunction

	task automatic report_failure(string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic compare_pixel(string name, pixel_t got, pixel_t exp);
		if (got !== exp)
			report_failure($sformatf("** Error: %s = %h, expected %h at x %0d y %0d",
				name, got, exp, pos_x, pos_y));
	endtask

	task automatic compare_flag(string name, logic got, logic exp);
		if (got !== exp)
			report_failure($sformatf("** Error: %s = %h, expected %h at x %0d y %0d",
				name, got, exp, pos_x, pos_y));
	endtask

	task automatic compare_ar_field(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	endtask

	// reads are INCR bursts of 4-byte beats to normal non-cacheable bufferable memory
	task automatic check_ar_attributes();
		compare_ar_field("m_axi_arsize", m_axi_arsize, 8'h02);
		compare_ar_field("m_axi_arburst", m_axi_arburst, 8'h01);
		compare_ar_field("m_axi_arlock", m_axi_arlock, 8'h00);
		compare_ar_field("m_axi_arcache", m_axi_arcache, 8'h03);
		compare_ar_field("m_axi_arprot", m_axi_arprot, 8'h00);
		compare_ar_field("m_axi_arqos", m_axi_arqos, 8'h00);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_fsync(logic enable);
		beat_count = 0;
		sof_count = 0;
		pos_x = 0;
		pos_y = 0;
		fsync = 1'b1;
		soft_resetn = enable;
		next_cycle();
		fsync = 1'b0;
		soft_resetn = 1'b0;
	endtask

	task automatic check_quiet(int cycles);
		repeat (cycles) begin
			next_cycle();
			compare_flag("m_axi_arvalid", m_axi_arvalid, 1'b0);
			compare_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
			compare_flag("sof", sof, 1'b0);
		end
	endtask

	task automatic run_frame(col_t left, col_t width, row_t top, row_t height,
			col_t dw, row_t dh, axi_addr_t base);
		int cycles;
		win_left = left;
		win_width = width;
		win_top = top;
		win_height = height;
		dst_width = dw;
		dst_height = dh;
		frame_addr = base;
		frame_beats = int'(dw) * int'(dh);
		pulse_fsync(1'b1);
		cycles = 0;
		while (beat_count < frame_beats) begin
			next_cycle();
			cycles++;
			if (cycles > FRAME_TIMEOUT)
				report_failure("timeout while waiting for the frame's stream beats");
		end
		// short gap so drain_done clears before the next fsync
		repeat (4) next_cycle();
		if (sof_count != 1)
			report_failure($sformatf("frame gave %0d sof pulses instead of one", sof_count));
	endtask

	// AXI read slave samples on the edge and drives just after it
	always @(posedge clk) begin
		ar_fire = m_axi_arvalid && m_axi_arready;
		r_fire = m_axi_rvalid && m_axi_rready;
		gaps = random_gaps;
		if (!resetn) begin
			burst_active = 1'b0;
			beats_left = 0;
			burst_addr = '0;
		end else begin
			if (r_fire) begin
				burst_addr = burst_addr + 4;
				beats_left = beats_left - 1;
				if (beats_left == 0)
					burst_active = 1'b0;
			end
			if (ar_fire) begin
				check_ar_attributes();
				burst_active = 1'b1;
				burst_addr = m_axi_araddr;
				beats_left = m_axi_arlen + 1;
			end
		end
		#1;
		// a presented beat stays until the master takes it
		if (!m_axi_rvalid || r_fire) begin
			m_axi_rvalid = burst_active && (!gaps || ($random(seed) & 3) != 0);
			m_axi_rdata = memory_word(burst_addr);
			m_axi_rlast = (beats_left == 1);
		end
		m_axi_arready = !burst_active && (!gaps || ($random(seed) & 1) != 0);
		m_axis_tready = !gaps || ($random(seed) & 3) != 0;
	end

	// stream checker
	always @(posedge clk) begin
		if (resetn && m_axis_tvalid && m_axis_tready) begin
			if (beat_count >= frame_beats)
				report_failure("stream beat arrived outside a frame");
			compare_pixel("m_axis_tdata", m_axis_tdata, expected_pixel(pos_x, pos_y));
			compare_flag("m_axis_tuser", m_axis_tuser, pos_x == 0 && pos_y == 0);
			compare_flag("m_axis_tlast", m_axis_tlast, pos_x == dst_width - 1);
			beat_count++;
			if (pos_x == dst_width - 1) begin
				pos_x = 0;
				pos_y++;
			end else begin
				pos_x++;
			end
		end
		if (resetn && sof)
			sof_count++;
		if (mm2s_adv_inst.mm2s_adv_assert_inst.assert_failures != 0)
			report_failure("a bound assertion on the DUT failed");
	end

	initial begin
		seed = 32'h39e9;
		clk = 1'b0;
		resetn = 1'b0;
		fsync = 1'b0;
		soft_resetn = 1'b0;
		img_width = 12'd1024;
		img_height = 12'd64;
		win_left = '0;
		win_width = '0;
		win_top = '0;
		win_height = '0;
		dst_width = 12'd1;
		dst_height = 12'd1;
		frame_addr = '0;
		m_axi_arready = 1'b0;
		m_axi_rdata = '0;
		m_axi_rlast = 1'b0;
		m_axi_rvalid = 1'b0;
		m_axis_tready = 1'b0;
		random_gaps = 1'b0;
		beat_count = 0;
		frame_beats = 0;
		sof_count = 0;
		pos_x = 0;
		pos_y = 0;

		repeat (8) next_cycle();
		resetn = 1'b1;
		check_quiet(20);

		// identity, crop at an unaligned column, downscale, upscale
		run_frame(12'd0, 12'd32, 12'd0, 12'd4, 12'd32, 12'd4, 32'h0002_0000);
		run_frame(12'd70, 12'd20, 12'd3, 12'd4, 12'd20, 12'd4, 32'h0002_0000);
		run_frame(12'd5, 12'd40, 12'd2, 12'd6, 12'd16, 12'd3, 32'h0002_0000);
		run_frame(12'd130, 12'd8, 12'd9, 12'd2, 12'd24, 12'd5, 32'h0002_0000);

		// random back-pressure and read gaps with lines split over several bursts
		random_gaps = 1'b1;
		run_frame(12'd100, 12'd120, 12'd5, 12'd7, 12'd45, 12'd5, 32'h0003_1000);
		run_frame(12'd13, 12'd50, 12'd20, 12'd9, 12'd30, 12'd4, 32'h0003_1000);

		// fsync without soft_resetn must leave the DUT idle
		frame_beats = 0;
		pulse_fsync(1'b0);
		check_quiet(60);
		run_frame(12'd64, 12'd16, 12'd1, 12'd3, 12'd16, 12'd3, 32'h0002_0000);

		if (mm2s_adv_inst.mm2s_adv_assert_inst.assert_failures == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			report_failure("a bound assertion on the DUT failed");
		end
	end

endmodule

`default_nettype wire

//--- verif/mm2s_adv_assert.sv
`timescale 1ns/10ps
`default_nettype none

module mm2s_adv_assert import mm2s_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic sof,
	input axi_addr_t m_axi_araddr,
	input logic [7:0] m_axi_arlen,
	input logic m_axi_arvalid,
	input logic m_axi_arready,
	input logic m_axi_rready,
	input logic m_axis_tvalid,
	input pixel_t m_axis_tdata,
	input logic m_axis_tuser,
	input logic m_axis_tlast,
	input logic m_axis_tready
);
	int assert_failures = 0;

	// read address holds until arready
	ar_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_axi_arvalid && !m_axi_arready |=>
		m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
	else begin
		$error("AR channel changed while waiting for arready");
		assert_failures = assert_failures + 1;
	end

	// stalled stream beat keeps its payload
	axis_hold: assert property (@(posedge clk) disable iff (!resetn)
		m_axis_tvalid && !m_axis_tready |=>
		m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser) &&
		$stable(m_axis_tlast))
	else begin
		$error("stream beat changed while tready was low");
		assert_failures = assert_failures + 1;
	end

	sof_pulse: assert property (@(posedge clk) disable iff (!resetn) sof |=> !sof)
	else begin
		$error("sof held for more than one cycle");
		assert_failures = assert_failures + 1;
	end

	reset_quiet: assert property (@(posedge clk)
		!resetn |=> !m_axi_arvalid && !m_axi_rready && !m_axis_tvalid &&
		!m_axis_tuser && !m_axis_tlast && !sof)
	else begin
		$error("handshake outputs not low after reset");
		assert_failures = assert_failures + 1;
	end

endmodule

bind mm2s_adv mm2s_adv_assert mm2s_adv_assert_inst (
	.clk(clk),
	.resetn(resetn),
	.sof(sof),
	.m_axi_araddr(m_axi_araddr),
	.m_axi_arlen(m_axi_arlen),
	.m_axi_arvalid(m_axi_arvalid),
	.m_axi_arready(m_axi_arready),
	.m_axi_rready(m_axi_rready),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tdata(m_axis_tdata),
	.m_axis_tuser(m_axis_tuser),
	.m_axis_tlast(m_axis_tlast),
	.m_axis_tready(m_axis_tready)
);

`default_nettype wire

//--- verilog/mm2s_adv.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm2s_consts.svh"

module mm2s_adv import mm2s_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic fsync,
	input logic soft_resetn,
	input col_t img_width,
	input row_t img_height,
	input col_t win_left,
	input col_t win_width,
	input row_t win_top,
	input row_t win_height,
	input col_t dst_width,
	input row_t dst_height,
	input axi_addr_t frame_addr,
	output logic sof,
	output axi_addr_t m_axi_araddr,
	output logic [7:0] m_axi_arlen,
	output logic [2:0] m_axi_arsize,
	output logic [1:0] m_axi_arburst,
	output logic m_axi_arlock,
	output logic [3:0] m_axi_arcache,
	output logic [2:0] m_axi_arprot,
	output logic [3:0] m_axi_arqos,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	input logic [`MM2S_DATA_WIDTH-1:0] m_axi_rdata,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready,
	output logic m_axis_tvalid,
	output pixel_t m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	input logic m_axis_tready
);
	localparam int WORD_BITS = $clog2(`MM2S_WORD_PIXELS);

	addr_seq_if line_seq ();
	line_wr_if wr_bus ();

	col_t line_head;
	logic [`MM2S_IMG_WBITS:0] span;
	logic [`MM2S_IMG_WBITS:0] win_right;
	logic [`MM2S_IMG_HBITS:0] win_bottom;
	logic window_ok;
	logic frame_start;
	logic last_line;
	logic fetch_ok;
	logic rd_en;
	col_t rd_index;
	pixel_t rd_pixel;
	logic line_ready;
	logic drain_done;

	axi_addr_t frame_offset_q;
	word_idx_t line_words_q;
	col_t read_offset_q;
	col_t win_width_q;
	row_t win_height_q;
	col_t dst_width_q;
	row_t dst_height_q;

	// first pixel position inside its 64-pixel burst
	assign line_head = win_left & col_t'(`MM2S_BURST_PIXELS - 1);
	assign span = line_head + win_width + col_t'(`MM2S_WORD_PIXELS - 1);

	// a window that runs off the image is not fetched
	assign win_right = win_left + win_width;
	assign win_bottom = win_top + win_height;
	assign window_ok = (win_right <= img_width) && (win_bottom <= img_height);

	always_ff @(posedge clk) begin
		if (fsync) begin
			frame_offset_q <= axi_addr_t'(win_left - line_head) +
				axi_addr_t'(win_top) * axi_addr_t'(`MM2S_STRIDE);
			line_words_q <= word_idx_t'(span >> WORD_BITS);
			read_offset_q <= line_head;
			win_width_q <= win_width;
			win_height_q <= win_height;
			dst_width_q <= dst_width;
			dst_height_q <= dst_height;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame_start <= 1'b0;
			last_line <= 1'b0;
		end else begin
			// geometry settles on this edge, the height scaler starts on the next
			frame_start <= fsync && soft_resetn && window_ok;
			if (fsync)
				last_line <= 1'b0;
			else if (wr_bus.sol)
				last_line <= line_seq.last;
		end
	end

	assign sof = wr_bus.eol && last_line;
	assign line_seq.ready = fetch_ok;

	scale_1d height_scaler (
		.clk(clk),
		.resetn(resetn),
		.start(frame_start),
		.src_len(win_height_q),
		.dst_len(dst_height_q),
		.base(frame_addr),
		.offset(frame_offset_q),
		.step(axi_addr_t'(`MM2S_STRIDE)),
		.seq(line_seq)
	);

	line_reader line_reader_inst (
		.clk(clk),
		.resetn(resetn),
		.line_words(line_words_q),
		.req(line_seq),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arlen(m_axi_arlen),
		.m_axi_arsize(m_axi_arsize),
		.m_axi_arburst(m_axi_arburst),
		.m_axi_arlock(m_axi_arlock),
		.m_axi_arcache(m_axi_arcache),
		.m_axi_arprot(m_axi_arprot),
		.m_axi_arqos(m_axi_arqos),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rlast(m_axi_rlast),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready),
		.wr(wr_bus)
	);

	pingpong_line_buffer line_buffer_inst (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.wr(wr_bus),
		.fetch_ok(fetch_ok),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_pixel(rd_pixel),
		.line_ready(line_ready),
		.drain_done(drain_done)
	);

	stream_out stream_out_inst (
		.clk(clk),
		.resetn(resetn),
		.fsync(fsync),
		.read_offset(read_offset_q),
		.win_width(win_width_q),
		.dst_width(dst_width_q),
		.line_ready(line_ready),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.rd_pixel(rd_pixel),
		.drain_done(drain_done),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tuser(m_axis_tuser),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tready(m_axis_tready)
	);

endmodule

`default_nettype wire

//--- verilog/stream_out.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm2s_consts.svh"

module stream_out import mm2s_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic fsync,
	input col_t read_offset,
	input col_t win_width,
	input col_t dst_width,
	input logic line_ready,
	output logic rd_en,
	output col_t rd_index,
	input pixel_t rd_pixel,
	output logic drain_done,
	output logic m_axis_tvalid,
	output pixel_t m_axis_tdata,
	output logic m_axis_tuser,
	output logic m_axis_tlast,
	input logic m_axis_tready
);
	addr_seq_if pix_seq ();

	logic line_start;
	logic draining;
	logic take;
	logic beat_done;

	scale_1d width_scaler (
		.clk(clk),
		.resetn(resetn),
		.start(line_start),
		.src_len(win_width),
		.dst_len(dst_width),
		.base('0),
		.offset(axi_addr_t'(read_offset)),
		.step(axi_addr_t'(1)),
		.seq(pix_seq)
	);

	// the output register only takes a new pixel when it is empty or moving
	assign pix_seq.ready = draining && (!m_axis_tvalid || m_axis_tready);
	assign take = pix_seq.valid && pix_seq.ready;

	assign rd_en = take;
	assign rd_index = pix_seq.addr[`MM2S_IMG_WBITS-1:0];
	// buffer read data lands with tvalid and holds while stalled
	assign m_axis_tdata = rd_pixel;
	assign beat_done = m_axis_tvalid && m_axis_tready;

	always_ff @(posedge clk) begin
		if (!resetn || fsync) begin
			line_start <= 1'b0;
			draining <= 1'b0;
		end else begin
			line_start <= line_ready && !draining && !line_start;
			if (line_start)
				draining <= 1'b1;
			else if (drain_done)
				draining <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tuser <= 1'b0;
			m_axis_tlast <= 1'b0;
			drain_done <= 1'b0;
		end else begin
			if (take)
				m_axis_tvalid <= 1'b1;
			else if (m_axis_tready)
				m_axis_tvalid <= 1'b0;

			// start of frame stays up until the first pixel goes out
			if (fsync)
				m_axis_tuser <= 1'b1;
			else if (beat_done)
				m_axis_tuser <= 1'b0;

			if (take)
				m_axis_tlast <= pix_seq.last;

			drain_done <= beat_done && m_axis_tlast;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pingpong_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm2s_consts.svh"

module pingpong_line_buffer import mm2s_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic fsync,
	line_wr_if.buffer wr,
	output logic fetch_ok,
	input logic rd_en,
	input col_t rd_index,
	output pixel_t rd_pixel,
	output logic line_ready,
	input logic drain_done
);
	localparam int LINE_WORDS = 1 << `MM2S_WORD_IDX_BITS;
	localparam int LANE_BITS = $clog2(`MM2S_WORD_PIXELS);

	beat_word_t line_ram [2][LINE_WORDS];

	// one-hot bank pointers, bit 1 selects the second RAM
	logic [1:0] wr_bank;
	logic [1:0] rd_bank;
	logic [1:0] full;
	logic fetching;
	word_idx_t rd_word;
	logic [LANE_BITS-1:0] rd_lane;

	assign rd_word = rd_index[`MM2S_IMG_WBITS-1:LANE_BITS];
	assign rd_lane = rd_index[LANE_BITS-1:0];

	// only one line in flight, and never into a bank still waiting to drain
	assign fetch_ok = !(|(wr_bank & full)) && !fetching;
	assign line_ready = |(rd_bank & full);

	always_ff @(posedge clk) begin
		if (!resetn || fsync) begin
			wr_bank <= 2'b01;
			rd_bank <= 2'b01;
			full <= 2'b00;
			fetching <= 1'b0;
		end else begin
			if (wr.eol)
				wr_bank <= {wr_bank[0], wr_bank[1]};
			if (drain_done)
				rd_bank <= {rd_bank[0], rd_bank[1]};

			full <= (full | ({2{wr.eol}} & wr_bank)) & ~({2{drain_done}} & rd_bank);

			if (wr.sol)
				fetching <= 1'b1;
			else if (wr.eol)
				fetching <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.wr_en)
			line_ram[wr_bank[1]][wr.wr_addr] <= wr.wr_data;
		if (rd_en)
			rd_pixel <= line_ram[rd_bank[1]][rd_word].pix[rd_lane];
	end

endmodule

`default_nettype wire

//--- verilog/line_reader.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm2s_consts.svh"

module line_reader import mm2s_pkg::*; (
	input logic clk,
	input logic resetn,
	input word_idx_t line_words,
	addr_seq_if.sink req,
	output axi_addr_t m_axi_araddr,
	output logic [7:0] m_axi_arlen,
	output logic [2:0] m_axi_arsize,
	output logic [1:0] m_axi_arburst,
	output logic m_axi_arlock,
	output logic [3:0] m_axi_arcache,
	output logic [2:0] m_axi_arprot,
	output logic [3:0] m_axi_arqos,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	input logic [`MM2S_DATA_WIDTH-1:0] m_axi_rdata,
	input logic m_axi_rlast,
	input logic m_axi_rvalid,
	output logic m_axi_rready,
	line_wr_if.writer wr
);
	localparam int BURST_BITS = $clog2(`MM2S_BURST_LEN) + 1;
	localparam int WORD_BYTES = `MM2S_DATA_WIDTH / 8;

	word_idx_t words_left;
	word_idx_t beat_idx;
	logic [BURST_BITS-1:0] burst_words;
	logic ar_done;
	logic beat;
	logic line_end;

	assign wr.sol = req.valid && req.ready;
	assign ar_done = m_axi_arvalid && m_axi_arready;
	assign beat = m_axi_rvalid && m_axi_rready;

	// full bursts while they fit, then a short one for the tail
	assign burst_words = (words_left >= word_idx_t'(`MM2S_BURST_LEN)) ?
		BURST_BITS'(`MM2S_BURST_LEN) : words_left[BURST_BITS-1:0];

	assign m_axi_arlen = 8'(burst_words - 1'b1);
	assign m_axi_arsize = 3'($clog2(WORD_BYTES));
	assign m_axi_arburst = 2'b01;
	assign m_axi_arlock = 1'b0;
	assign m_axi_arcache = 4'b0011;
	assign m_axi_arprot = 3'b000;
	assign m_axi_arqos = 4'b0000;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_axi_arvalid <= 1'b0;
			m_axi_rready <= 1'b0;
			wr.wr_en <= 1'b0;
			line_end <= 1'b0;
			wr.eol <= 1'b0;
		end else begin
			wr.wr_en <= beat;
			line_end <= beat && m_axi_rlast && (words_left == '0);
			wr.eol <= line_end;

			// one burst outstanding at a time, next AR after rlast
			if (wr.sol || (beat && m_axi_rlast && words_left != '0))
				m_axi_arvalid <= 1'b1;
			else if (ar_done)
				m_axi_arvalid <= 1'b0;

			if (ar_done)
				m_axi_rready <= 1'b1;
			else if (beat && m_axi_rlast)
				m_axi_rready <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr.sol) begin
			m_axi_araddr <= req.addr;
			words_left <= line_words;
		end else if (ar_done) begin
			m_axi_araddr <= m_axi_araddr + burst_words * WORD_BYTES;
			words_left <= words_left - burst_words;
		end

		if (wr.sol)
			beat_idx <= '0;
		else if (beat)
			beat_idx <= beat_idx + 1'b1;

		if (beat) begin
			wr.wr_addr <= beat_idx;
			wr.wr_data.raw <= m_axi_rdata;
		end
	end

endmodule

`default_nettype wire

//--- verilog/scale_1d.sv
`timescale 1ns/10ps
`default_nettype none

`include "mm2s_consts.svh"

module scale_1d import mm2s_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic start,
	input col_t src_len,
	input col_t dst_len,
	input axi_addr_t base,
	input axi_addr_t offset,
	input axi_addr_t step,
	addr_seq_if.source seq
);
	col_t quot;
	col_t frac;
	col_t dst_q;
	col_t idx;
	col_t rem;
	col_t cnt;
	axi_addr_t origin;
	logic take;
	logic wrapped;
	logic [`MM2S_IMG_WBITS:0] rem_sum;

	assign take = seq.valid && seq.ready;

	// per output the index moves by quot, plus one more when the remainder wraps
	assign rem_sum = rem + frac;
	assign wrapped = (rem_sum >= dst_q);

	assign seq.last = (cnt == dst_q - 1'b1);
	assign seq.addr = origin + idx * step;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			seq.valid <= 1'b0;
		end else if (start) begin
			seq.valid <= 1'b1;
		end else if (take && seq.last) begin
			seq.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			quot <= src_len / dst_len;
			frac <= src_len % dst_len;
			dst_q <= dst_len;
			origin <= base + offset;
			idx <= '0;
			rem <= '0;
			cnt <= '0;
		end else if (take) begin
			cnt <= cnt + 1'b1;
			idx <= idx + quot + wrapped;
			if (wrapped)
				rem <= rem_sum[`MM2S_IMG_WBITS-1:0] - dst_q;
			else
				rem <= rem_sum[`MM2S_IMG_WBITS-1:0];
		end
	end

endmodule

`default_nettype wire

//--- verilog/addr_seq_if.sv
`timescale 1ns/10ps
`default_nettype none

interface addr_seq_if import mm2s_pkg::*; ();
	logic valid;
	logic ready;
	logic last;
	axi_addr_t addr;

	modport source (output valid, last, addr, input ready);
	// ready comes from the gating around the consumer, the sink only sees it
	modport sink (input valid, ready, last, addr);
endinterface

`default_nettype wire

//--- verilog/line_wr_if.sv
`timescale 1ns/10ps
`default_nettype none

interface line_wr_if import mm2s_pkg::*; ();
	logic wr_en;
	word_idx_t wr_addr;
	beat_word_t wr_data;
	// sol when a line address is accepted
	logic sol;
	// eol the cycle after the last beat of the line is written
	logic eol;

	modport writer (output wr_en, wr_addr, wr_data, sol, eol);
	modport buffer (input wr_en, wr_addr, wr_data, sol, eol);
endinterface

`default_nettype wire

//--- verilog/mm2s_pkg.sv
`default_nettype none

`include "mm2s_consts.svh"

package mm2s_pkg;

	typedef logic [`MM2S_PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [`MM2S_ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [`MM2S_IMG_WBITS-1:0] col_t;
	typedef logic [`MM2S_IMG_HBITS-1:0] row_t;
	typedef logic [`MM2S_WORD_IDX_BITS-1:0] word_idx_t;

	// one read beat: stored whole, read back one pixel lane at a time
	typedef union packed {
		logic [`MM2S_DATA_WIDTH-1:0] raw;
		pixel_t [`MM2S_WORD_PIXELS-1:0] pix;
	} beat_word_t;

endpackage

`default_nettype wire

//--- verilog/mm2s_consts.svh
`ifndef MM2S_CONSTS_SVH
`define MM2S_CONSTS_SVH

// pixel and bus geometry
`define MM2S_PIXEL_WIDTH 8
`define MM2S_DATA_WIDTH 32
`define MM2S_ADDR_WIDTH 32
`define MM2S_WORD_PIXELS 4

// AXI bursts
`define MM2S_BURST_LEN 16
`define MM2S_BURST_PIXELS 64

// image coordinates and memory layout
`define MM2S_IMG_WBITS 12
`define MM2S_IMG_HBITS 12
`define MM2S_STRIDE 1024

// word index inside one buffered line, IMG_WBITS minus the pixel lane bits
`define MM2S_WORD_IDX_BITS 10

`endif
